/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // default geometry of the processor and memory ports
    parameter int ADDR_WIDTH_DEF = 16;  // byte address
    parameter int DATA_WIDTH_DEF = 32;

    // which master currently holds the external memory port
    typedef enum logic [0:0]
    {
        OWNER_BYPASS = 1'b0,
        OWNER_CACHE  = 1'b1
    } owner_t;

    // which path owns the outstanding processor request
    typedef enum logic [0:0]
    {
        PATH_BYPASS = 1'b0,
        PATH_CACHE  = 1'b1
    } path_t;

endpackage

`default_nettype wire

/* design/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    parameter int INDEX_BITS_DEF = 4;  // 16 lines

    // miss handling walks WB_* only for a dirty victim
    typedef enum logic [2:0]
    {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        WB_REQ    = 3'd2,
        WB_WAIT   = 3'd3,
        FILL_REQ  = 3'd4,
        FILL_WAIT = 3'd5,
        RESPOND   = 3'd6
    } ctrl_state_t;

endpackage

`default_nettype wire

/* design/mem_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if #(
    parameter int ADDR_WIDTH = bus_pkg::ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH_DEF
);

    logic                    req;
    logic                    gnt;
    logic                    rvalid;
    logic [ADDR_WIDTH-1:0]   addr;
    logic                    we;
    logic [DATA_WIDTH/8-1:0] be;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [DATA_WIDTH-1:0]   rdata;

    modport master (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata
    );

    modport slave (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

/* design/proc_port_router.sv */
`timescale 1ns/10ps
`default_nettype none

module proc_port_router #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    capture_en_i,

    input  logic                    proc_req_i,
    input  logic [ADDR_WIDTH-1:0]   proc_addr_i,
    input  logic                    proc_we_i,
    input  logic [DATA_WIDTH/8-1:0] proc_be_i,
    input  logic [DATA_WIDTH-1:0]   proc_wdata_i,
    output logic                    proc_gnt_o,
    output logic                    proc_rvalid_o,
    output logic [DATA_WIDTH-1:0]   proc_rdata_o,

    mem_bus_if.master               byp_bus,
    mem_bus_if.master               cache_bus
);

    bus_pkg::path_t path_q;
    bus_pkg::path_t path_sel;
    logic           busy_q;     // request seen, waiting for rvalid
    logic           granted_q;  // request transferred, waiting for rvalid
    logic           fwd_req;

    // mode is only looked at while no request is in flight
    always_comb
    begin
        if (busy_q)
            path_sel = path_q;
        else if (capture_en_i)
            path_sel = bus_pkg::PATH_BYPASS;
        else
            path_sel = bus_pkg::PATH_CACHE;
    end

    assign fwd_req = proc_req_i && !granted_q;

    assign byp_bus.req   = fwd_req && (path_sel == bus_pkg::PATH_BYPASS);
    assign byp_bus.addr  = proc_addr_i;
    assign byp_bus.we    = proc_we_i;
    assign byp_bus.be    = proc_be_i;
    assign byp_bus.wdata = proc_wdata_i;

    assign cache_bus.req   = fwd_req && (path_sel == bus_pkg::PATH_CACHE);
    assign cache_bus.addr  = proc_addr_i;
    assign cache_bus.we    = proc_we_i;
    assign cache_bus.be    = proc_be_i;
    assign cache_bus.wdata = proc_wdata_i;

    always_comb
    begin
        if (path_sel == bus_pkg::PATH_BYPASS)
        begin
            proc_gnt_o    = byp_bus.gnt;
            proc_rvalid_o = byp_bus.rvalid;
            proc_rdata_o  = byp_bus.rdata;
        end
        else
        begin
            proc_gnt_o    = cache_bus.gnt;
            proc_rvalid_o = cache_bus.rvalid;
            proc_rdata_o  = cache_bus.rdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy_q    <= 1'b0;
            granted_q <= 1'b0;
            path_q    <= bus_pkg::PATH_BYPASS;
        end
        else if (proc_rvalid_o)
        begin
            busy_q    <= 1'b0;
            granted_q <= 1'b0;
        end
        else
        begin
            if (fwd_req && !busy_q)
            begin
                busy_q <= 1'b1;
                path_q <= path_sel;  // lock the path for this request
            end
            if (proc_gnt_o)
                granted_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32,
    parameter int INDEX_BITS = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    mem_bus_if.slave  cache_bus,
    mem_bus_if.master fill_bus
);

    localparam int BE_W     = DATA_WIDTH / 8;
    localparam int OFF_BITS = $clog2(BE_W);
    localparam int TAG_BITS = ADDR_WIDTH - OFF_BITS - INDEX_BITS;
    localparam int LINES    = 2 ** INDEX_BITS;

    cache_pkg::ctrl_state_t state_q;

    logic [TAG_BITS-1:0]   tag_mem  [LINES];
    logic [DATA_WIDTH-1:0] data_mem [LINES];
    logic [LINES-1:0]      valid_q;
    logic [LINES-1:0]      dirty_q;
    logic [DATA_WIDTH-1:0] rdata_q;

    logic [ADDR_WIDTH-1:0] word_addr;
    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    logic                  hit;
    logic [ADDR_WIDTH-1:0] wb_addr;
    logic [ADDR_WIDTH-1:0] refill_addr;

    // request fields are held by the router until gnt
    assign word_addr = cache_bus.addr >> OFF_BITS;
    assign idx       = word_addr[INDEX_BITS-1:0];
    assign tag       = word_addr[INDEX_BITS +: TAG_BITS];
    assign hit       = valid_q[idx] && (tag_mem[idx] == tag);

    assign wb_addr     = ADDR_WIDTH'({tag_mem[idx], idx}) << OFF_BITS;  // victim line
    assign refill_addr = ADDR_WIDTH'({tag, idx}) << OFF_BITS;

    assign cache_bus.gnt    = (state_q == cache_pkg::LOOKUP) && hit;
    assign cache_bus.rvalid = (state_q == cache_pkg::RESPOND);
    assign cache_bus.rdata  = rdata_q;

    assign fill_bus.req   = (state_q == cache_pkg::WB_REQ) || (state_q == cache_pkg::FILL_REQ);
    assign fill_bus.we    = (state_q == cache_pkg::WB_REQ);
    assign fill_bus.addr  = (state_q == cache_pkg::WB_REQ) ? wb_addr : refill_addr;
    assign fill_bus.be    = '1;  // whole word on write-back
    assign fill_bus.wdata = data_mem[idx];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= cache_pkg::IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end
        else
        begin
            case (state_q)
                cache_pkg::IDLE:
                begin
                    if (cache_bus.req)
                        state_q <= cache_pkg::LOOKUP;
                end
                cache_pkg::LOOKUP:
                begin
                    if (hit)
                    begin
                        state_q <= cache_pkg::RESPOND;
                        if (cache_bus.we)
                            dirty_q[idx] <= 1'b1;
                    end
                    else if (valid_q[idx] && dirty_q[idx])
                        state_q <= cache_pkg::WB_REQ;
                    else
                        state_q <= cache_pkg::FILL_REQ;
                end
                cache_pkg::WB_REQ:
                begin
                    if (fill_bus.gnt)
                        state_q <= cache_pkg::WB_WAIT;
                end
                cache_pkg::WB_WAIT:
                begin
                    if (fill_bus.rvalid)
                        state_q <= cache_pkg::FILL_REQ;
                end
                cache_pkg::FILL_REQ:
                begin
                    if (fill_bus.gnt)
                        state_q <= cache_pkg::FILL_WAIT;
                end
                cache_pkg::FILL_WAIT:
                begin
                    if (fill_bus.rvalid)
                    begin
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= 1'b0;
                        state_q      <= cache_pkg::LOOKUP;  // retried as a hit
                    end
                end
                cache_pkg::RESPOND:
                    state_q <= cache_pkg::IDLE;
                default:
                    state_q <= cache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state_q == cache_pkg::FILL_WAIT) && fill_bus.rvalid)
        begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= fill_bus.rdata;
        end
        else if (cache_bus.gnt && cache_bus.we)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (cache_bus.be[b])
                    data_mem[idx][8*b +: 8] <= cache_bus.wdata[8*b +: 8];
            end
        end
        if (cache_bus.gnt)
            rdata_q <= data_mem[idx];  // old word on a write
    end

    // lookup and miss handling index with the live request fields
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        cache_bus.req && !cache_bus.gnt |=> cache_bus.req && $stable(cache_bus.addr)
            && $stable(cache_bus.we));

    a_fill_rvalid_waited: assert property (@(posedge clk) disable iff (!rst_n)
        fill_bus.rvalid |-> (state_q == cache_pkg::WB_WAIT) || (state_q == cache_pkg::FILL_WAIT));

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    mem_bus_if.slave                byp_bus,
    mem_bus_if.slave                fill_bus,

    input  logic                    mem_gnt_i,
    input  logic                    mem_rvalid_i,
    input  logic [DATA_WIDTH-1:0]   mem_rdata_i,
    output logic                    mem_req_o,
    output logic [ADDR_WIDTH-1:0]   mem_addr_o,
    output logic                    mem_we_o,
    output logic [DATA_WIDTH/8-1:0] mem_be_o,
    output logic [DATA_WIDTH-1:0]   mem_wdata_o
);

    bus_pkg::owner_t owner_q;
    bus_pkg::owner_t cur;
    logic            owned_q;

    // bypass wins a tie; a held owner keeps the port until its rvalid
    always_comb
    begin
        if (owned_q)
            cur = owner_q;
        else if (byp_bus.req)
            cur = bus_pkg::OWNER_BYPASS;
        else
            cur = bus_pkg::OWNER_CACHE;
    end

    always_comb
    begin
        if (cur == bus_pkg::OWNER_BYPASS)
        begin
            mem_req_o   = byp_bus.req;
            mem_addr_o  = byp_bus.addr;
            mem_we_o    = byp_bus.we;
            mem_be_o    = byp_bus.be;
            mem_wdata_o = byp_bus.wdata;
        end
        else
        begin
            mem_req_o   = fill_bus.req;
            mem_addr_o  = fill_bus.addr;
            mem_we_o    = fill_bus.we;
            mem_be_o    = fill_bus.be;
            mem_wdata_o = fill_bus.wdata;
        end
    end

    assign byp_bus.gnt  = mem_gnt_i && mem_req_o && (cur == bus_pkg::OWNER_BYPASS);
    assign fill_bus.gnt = mem_gnt_i && mem_req_o && (cur == bus_pkg::OWNER_CACHE);

    assign byp_bus.rvalid  = mem_rvalid_i && owned_q && (owner_q == bus_pkg::OWNER_BYPASS);
    assign fill_bus.rvalid = mem_rvalid_i && owned_q && (owner_q == bus_pkg::OWNER_CACHE);
    assign byp_bus.rdata   = mem_rdata_i;
    assign fill_bus.rdata  = mem_rdata_i;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            owned_q <= 1'b0;
            owner_q <= bus_pkg::OWNER_BYPASS;
        end
        else if (owned_q)
        begin
            if (mem_rvalid_i)
                owned_q <= 1'b0;
        end
        else if (mem_req_o)
        begin
            owned_q <= 1'b1;  // lock at first req so addr stays put under back-pressure
            owner_q <= cur;
        end
    end

    // a stalled request stays on the port unchanged
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o));

    a_rvalid_owned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rvalid_i |-> owned_q);

endmodule

`default_nettype wire

/* design/cache_front_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_front_top #(
    parameter int ADDR_WIDTH = bus_pkg::ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH_DEF,
    parameter int INDEX_BITS = cache_pkg::INDEX_BITS_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    capture_en_i,

    input  logic                    proc_req_i,
    input  logic [ADDR_WIDTH-1:0]   proc_addr_i,
    input  logic                    proc_we_i,
    input  logic [DATA_WIDTH/8-1:0] proc_be_i,
    input  logic [DATA_WIDTH-1:0]   proc_wdata_i,
    output logic                    proc_gnt_o,
    output logic                    proc_rvalid_o,
    output logic [DATA_WIDTH-1:0]   proc_rdata_o,

    input  logic                    mem_gnt_i,
    input  logic                    mem_rvalid_i,
    input  logic [DATA_WIDTH-1:0]   mem_rdata_i,
    output logic                    mem_req_o,
    output logic [ADDR_WIDTH-1:0]   mem_addr_o,
    output logic                    mem_we_o,
    output logic [DATA_WIDTH/8-1:0] mem_be_o,
    output logic [DATA_WIDTH-1:0]   mem_wdata_o
);

    mem_bus_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) byp_bus ();
    mem_bus_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) cache_bus ();
    mem_bus_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) fill_bus ();

    proc_port_router #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_router (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture_en_i  (capture_en_i),
        .proc_req_i    (proc_req_i),
        .proc_addr_i   (proc_addr_i),
        .proc_we_i     (proc_we_i),
        .proc_be_i     (proc_be_i),
        .proc_wdata_i  (proc_wdata_i),
        .proc_gnt_o    (proc_gnt_o),
        .proc_rvalid_o (proc_rvalid_o),
        .proc_rdata_o  (proc_rdata_o),
        .byp_bus       (byp_bus.master),
        .cache_bus     (cache_bus.master)
    );

    cache_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .INDEX_BITS (INDEX_BITS)
    ) u_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .cache_bus (cache_bus.slave),
        .fill_bus  (fill_bus.master)
    );

    mem_arbiter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .byp_bus      (byp_bus.slave),
        .fill_bus     (fill_bus.slave),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_we_o     (mem_we_o),
        .mem_be_o     (mem_be_o),
        .mem_wdata_o  (mem_wdata_o)
    );

endmodule

`default_nettype wire

/* verification/tb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_i,
    input  logic [ADDR_WIDTH-1:0]   addr_i,
    input  logic                    we_i,
    input  logic [DATA_WIDTH/8-1:0] be_i,
    input  logic [DATA_WIDTH-1:0]   wdata_i,
    output logic                    gnt_o,
    output logic                    rvalid_o,
    output logic [DATA_WIDTH-1:0]   rdata_o,
    output int                      req_count_o
);

    localparam int OFF_BITS = $clog2(DATA_WIDTH / 8);
    localparam int WORDS    = 2 ** (ADDR_WIDTH - OFF_BITS);

    logic [DATA_WIDTH-1:0] mem_q [WORDS];
    logic [31:0]           lfsr;
    logic [1:0]            delay;
    logic [DATA_WIDTH-1:0] word;
    int                    widx;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // taps 32 22 2 1
    endfunction

    initial
    begin
        gnt_o       = 1'b0;
        rvalid_o    = 1'b0;
        rdata_o     = '0;
        req_count_o = 0;
        lfsr        = 32'h6008_f5f1;
        for (int i = 0; i < WORDS; i++)
            mem_q[i] = '0;
        forever
        begin
            @(negedge clk);
            gnt_o    <= 1'b0;
            rvalid_o <= 1'b0;
            if (rst_n && req_i)
            begin
                for (int b = 0; b < 2; b++)
                begin
                    delay = {delay[0], lfsr[0]};  // one lfsr step per bit
                    lfsr  = lfsr_next(lfsr);
                end
                repeat (delay) @(negedge clk);
                gnt_o <= 1'b1;
                @(posedge clk);  // request transfers on this edge
                widx = int'(addr_i >> OFF_BITS);
                word = mem_q[widx];
                if (we_i)
                begin
                    for (int b = 0; b < DATA_WIDTH / 8; b++)
                    begin
                        if (be_i[b])
                            word[8*b +: 8] = wdata_i[8*b +: 8];
                    end
                end
                mem_q[widx] = word;
                req_count_o = req_count_o + 1;
                @(negedge clk);
                gnt_o    <= 1'b0;
                rvalid_o <= 1'b1;
                rdata_o  <= word;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/cache_front_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_front_tb;

    localparam int AW       = bus_pkg::ADDR_WIDTH_DEF;
    localparam int DW       = bus_pkg::DATA_WIDTH_DEF;
    localparam int BW       = DW / 8;
    localparam int OFF_BITS = $clog2(BW);
    localparam int CYCLES_PER_VECTOR = 40;

    logic          clk;
    logic          rst_n;
    logic          capture_en_i;
    logic          proc_req_i;
    logic [AW-1:0] proc_addr_i;
    logic          proc_we_i;
    logic [BW-1:0] proc_be_i;
    logic [DW-1:0] proc_wdata_i;
    logic          proc_gnt_o;
    logic          proc_rvalid_o;
    logic [DW-1:0] proc_rdata_o;
    logic          mem_gnt_i;
    logic          mem_rvalid_i;
    logic [DW-1:0] mem_rdata_i;
    logic          mem_req_o;
    logic [AW-1:0] mem_addr_o;
    logic          mem_we_o;
    logic [BW-1:0] mem_be_o;
    logic [DW-1:0] mem_wdata_o;
    int            mem_req_count;

    logic          v_cap   [$];
    logic          v_we    [$];
    logic [BW-1:0] v_be    [$];
    logic [AW-1:0] v_addr  [$];
    logic [DW-1:0] v_wdata [$];
    logic [DW-1:0] v_exp   [$];
    int            v_mreq  [$];
    logic          loaded = 1'b0;

    cache_front_top #(
        .ADDR_WIDTH (AW),
        .DATA_WIDTH (DW)
    ) u_cache_front_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture_en_i  (capture_en_i),
        .proc_req_i    (proc_req_i),
        .proc_addr_i   (proc_addr_i),
        .proc_we_i     (proc_we_i),
        .proc_be_i     (proc_be_i),
        .proc_wdata_i  (proc_wdata_i),
        .proc_gnt_o    (proc_gnt_o),
        .proc_rvalid_o (proc_rvalid_o),
        .proc_rdata_o  (proc_rdata_o),
        .mem_gnt_i     (mem_gnt_i),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_we_o      (mem_we_o),
        .mem_be_o      (mem_be_o),
        .mem_wdata_o   (mem_wdata_o)
    );

    tb_mem_model #(
        .ADDR_WIDTH (AW),
        .DATA_WIDTH (DW)
    ) u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (mem_req_o),
        .addr_i      (mem_addr_o),
        .we_i        (mem_we_o),
        .be_i        (mem_be_o),
        .wdata_i     (mem_wdata_o),
        .gnt_o       (mem_gnt_i),
        .rvalid_o    (mem_rvalid_i),
        .rdata_o     (mem_rdata_i),
        .req_count_o (mem_req_count)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    function automatic logic [DW-1:0] byte_mask(input logic [BW-1:0] be);
        logic [DW-1:0] m;
        for (int b = 0; b < BW; b++)
            m[8*b +: 8] = {8{be[b]}};
        return m;
    endfunction

    task automatic load_vectors();
        int          fd;
        string       line;
        logic [31:0] cap, we, be, addr, wdata, exp, mreq;
        fd = $fopen("verification/cache_front_vectors.txt", "r");
        if (fd == 0)
            abort_run("could not open verification/cache_front_vectors.txt");
        while (!$feof(fd))
        begin
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() < 2 || line[0] == "/")
                continue;  // comment or blank line
            if ($sscanf(line, "%h %h %h %h %h %h %h", cap, we, be, addr, wdata, exp, mreq) != 7)
                abort_run({"malformed line in the vector file: ", line});
            v_cap.push_back(cap[0]);
            v_we.push_back(we[0]);
            v_be.push_back(be[BW-1:0]);
            v_addr.push_back(addr[AW-1:0]);
            v_wdata.push_back(wdata[DW-1:0]);
            v_exp.push_back(exp[DW-1:0]);
            v_mreq.push_back(int'(mreq));
        end
        $fclose(fd);
    endtask

    // a capture request shows up unchanged on the memory port in its grant cycle
    task automatic check_passthrough(input int k);
        assert (mem_req_o && mem_gnt_i)
        else abort_run($sformatf("capture vector %0d was granted without a memory port grant", k));
        assert (mem_addr_o === v_addr[k])
        else abort_run($sformatf("ERROR mem_addr_o vector %0d: got %h, expected %h",
                                 k, mem_addr_o, v_addr[k]));
        assert (mem_we_o === v_we[k] && mem_be_o === v_be[k])
        else abort_run($sformatf("ERROR mem_we_o/mem_be_o vector %0d: got %h/%h, expected %h/%h",
                                 k, mem_we_o, mem_be_o, v_we[k], v_be[k]));
        if (v_we[k])
        begin
            assert (mem_wdata_o === v_wdata[k])
            else abort_run($sformatf("ERROR mem_wdata_o vector %0d: got %h, expected %h",
                                     k, mem_wdata_o, v_wdata[k]));
        end
    endtask

    task automatic run_vector(input int k);
        int            count_before;
        logic [DW-1:0] mask;
        logic [DW-1:0] stored;
        @(negedge clk);
        capture_en_i <= v_cap[k];
        proc_req_i   <= 1'b1;
        proc_addr_i  <= v_addr[k];
        proc_we_i    <= v_we[k];
        proc_be_i    <= v_be[k];
        proc_wdata_i <= v_wdata[k];
        count_before = mem_req_count;
        do
            @(posedge clk);
        while (!proc_gnt_o);
        if (v_cap[k])
            check_passthrough(k);
        @(negedge clk);
        proc_req_i <= 1'b0;
        do
            @(posedge clk);
        while (!proc_rvalid_o);
        if (!v_we[k])
        begin
            assert (proc_rdata_o === v_exp[k])
            else abort_run($sformatf("ERROR proc_rdata_o vector %0d addr %h: got %h, expected %h",
                                     k, v_addr[k], proc_rdata_o, v_exp[k]));
        end
        @(negedge clk);
        assert (mem_req_count - count_before == v_mreq[k])
        else abort_run($sformatf("ERROR mem_req_count vector %0d: got %h new requests, expected %h",
                                 k, mem_req_count - count_before, v_mreq[k]));
        if (v_cap[k] && v_we[k])
        begin
            mask   = byte_mask(v_be[k]);
            stored = u_mem.mem_q[v_addr[k] >> OFF_BITS];  // bypass write lands in memory directly
            assert ((stored & mask) === (v_wdata[k] & mask))
            else abort_run($sformatf("ERROR mem_q vector %0d addr %h: got %h, expected %h under %h",
                                     k, v_addr[k], stored, v_wdata[k], mask));
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        capture_en_i = 1'b0;
        proc_req_i   = 1'b0;
        proc_addr_i  = '0;
        proc_we_i    = 1'b0;
        proc_be_i    = '0;
        proc_wdata_i = '0;
        load_vectors();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        repeat (2)
        begin
            @(posedge clk);
            assert (!proc_gnt_o && !proc_rvalid_o && !mem_req_o)
            else abort_run($sformatf("ERROR proc_gnt_o %h proc_rvalid_o %h mem_req_o %h, expected 0",
                                     proc_gnt_o, proc_rvalid_o, mem_req_o));
        end
        for (int k = 0; k < v_addr.size(); k++)
            run_vector(k);
        $display("** PASS **");
        $finish;
    end

    // run length scales with the number of transactions
    initial
    begin
        wait (loaded);
        repeat (v_addr.size() * CYCLES_PER_VECTOR) @(posedge clk);
        abort_run($sformatf("timeout: the transactions did not complete within %0d cycles",
                            v_addr.size() * CYCLES_PER_VECTOR));
    end

endmodule

`default_nettype wire

/* verification/cache_front_vectors.txt */
// columns in hex: cap we be addr wdata exp_rdata mem_reqs (cap 1 = capture mode, 0 = cached)
// exp_rdata is checked on reads only; mem_reqs is the number of memory requests caused
// capture write and read back
1 1 f 0010 11223344 00000000 1
1 0 f 0010 00000000 11223344 1
// cached read miss then hit
1 1 f 0020 a5a50f0f 00000000 1
0 0 f 0020 00000000 a5a50f0f 1
0 0 f 0020 00000000 a5a50f0f 0
// partial cached write, memory stays old until eviction
0 1 5 0020 12345678 00000000 0
0 0 f 0020 00000000 a5340f78 0
1 0 f 0020 00000000 a5a50f0f 1
// dirty line at 0010 evicted by 0050
0 1 f 0010 cafebabe 00000000 1
0 0 f 0050 00000000 00000000 2
1 0 f 0010 00000000 cafebabe 1
// dirty line at 0020 evicted by 0060
0 0 f 0060 00000000 00000000 2
1 0 f 0020 00000000 a5340f78 1
// clean victim, then top byte write and eviction by 0090
0 0 f 0010 00000000 cafebabe 1
0 1 8 0010 99000000 00000000 0
0 0 f 0010 00000000 99febabe 0
1 1 3 0090 0000beef 00000000 1
0 0 f 0090 00000000 0000beef 2
1 0 f 0010 00000000 99febabe 1
0 0 f 0090 00000000 0000beef 0

/* all.f */
design/bus_pkg.sv
design/cache_pkg.sv
design/mem_bus_if.sv
design/proc_port_router.sv
design/cache_ctrl.sv
design/mem_arbiter.sv
design/cache_front_top.sv
verification/tb_mem_model.sv
verification/cache_front_tb.sv

/* Bender.yml */
package:
  name: cache_front

sources:
  - files:
      - design/bus_pkg.sv
      - design/cache_pkg.sv
      - design/mem_bus_if.sv
      - design/proc_port_router.sv
      - design/cache_ctrl.sv
      - design/mem_arbiter.sv
      - design/cache_front_top.sv
  - target: test
    files:
      - verification/tb_mem_model.sv
      - verification/cache_front_tb.sv
